// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== filelist.f ====
+incdir+verilog
verilog/fetch_pkg.sv
verilog/fetch_pc_gen.sv
verilog/fetch_bpu.sv
verilog/fetch_queue.sv
verilog/fetch_top.sv
testbench/fetch_asserts.sv
testbench/tb_fetch_top.sv

// ==== testbench/fetch_asserts.sv ====
// Concurrent checks on reset, memory enable and flush, bound into fetch_top
`timescale 1ns/1ps
`default_nettype none

module fetch_asserts (
   input wire clk,
   input wire rst_n_i,
   input wire flush_i,
   input wire imem_en_i,
   input wire queue_ready_i,
   input wire id_valid_i
);
   int fail_cnt = 0;

   // Queue reads empty once a reset edge has been seen
   reset_empty: assert property (@(posedge clk) !rst_n_i |=> !id_valid_i)
   else
   begin
      fail_cnt = fail_cnt + 1;
      $error("id_valid_o high after a reset edge");
   end

   // Back-pressure stops the memory unless a flush empties the queue
   no_fetch_full: assert property (@(posedge clk) disable iff (!rst_n_i)
      (!queue_ready_i && !flush_i) |-> !imem_en_i)
   else
   begin
      fail_cnt = fail_cnt + 1;
      $error("memory enabled while the queue is not ready");
   end

   flush_empties: assert property (@(posedge clk) disable iff (!rst_n_i)
      flush_i |=> !id_valid_i)
   else
   begin
      fail_cnt = fail_cnt + 1;
      $error("queue not empty after a flush");
   end

endmodule

bind fetch_top fetch_asserts u_asserts (
   .clk           (clk),
   .rst_n_i       (rst_n_i),
   .flush_i       (flush_i),
   .imem_en_i     (imem_en_o),
   .queue_ready_i (queue_ready),
   .id_valid_i    (id_valid_o)
);

`default_nettype wire

// ==== testbench/tb_fetch_top.sv ====
// Testbench for the fetch unit with memory model, BTB reference model and stream checks
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module tb_fetch_top;

   logic                                   clk;
   logic                                   rst_n_i;
   logic                                   flush_i;
   fetch_pkg::addr_t                       flush_tgt_i;
   logic                                   imem_en_o;
   fetch_pkg::addr_t                       imem_addr_o;
   logic [`FETCH_WIDTH*`FETCH_INSN_DW-1:0] imem_rdata_i;
   logic                                   bpu_wb_i;
   fetch_pkg::addr_t                       bpu_wb_pc_i;
   logic                                   bpu_wb_taken_i;
   fetch_pkg::addr_t                       bpu_wb_tgt_i;
   logic                                   id_valid_o;
   fetch_pkg::insn_t                       id_ins_o;
   fetch_pkg::addr_t                       id_pc_o;
   logic                                   id_pred_taken_o;
   logic                                   id_pop_i;

   // Reference BTB with one entry per PC[5:2]
   logic                 mdl_vld [`FETCH_BTB_ENTRIES];
   fetch_pkg::addr_t     mdl_pc  [`FETCH_BTB_ENTRIES];
   fetch_pkg::addr_t     mdl_tgt [`FETCH_BTB_ENTRIES];
   fetch_pkg::cnt2_t     mdl_cnt [`FETCH_BTB_ENTRIES];

   fetch_pkg::addr_t     mem_addr_q;
   fetch_pkg::addr_t     exp_pc;
   int                   seed;
   int                   errors;
   int                   checks;
   int                   pop_count;
   int                   pred_seen;
   int                   tests;
   int                   test_start;
   int                   mark;

   fetch_top u_fetch_top (.*);

   always #50 clk = ~clk;

   function automatic fetch_pkg::insn_t mem_word(input fetch_pkg::addr_t a);
      return a ^ 32'hA5A5_0000;
   endfunction

   function automatic logic predict_taken(input fetch_pkg::addr_t pc);
      return mdl_vld[pc[5:2]] && (mdl_pc[pc[5:2]][31:2] == pc[31:2]) && mdl_cnt[pc[5:2]][1];
   endfunction

   // Next PC of the instruction stream as the decoder should see it
   function automatic fetch_pkg::addr_t next_expected_pc(input fetch_pkg::addr_t pc);
      if (predict_taken(pc))
         return mdl_tgt[pc[5:2]];
      return pc + 32'd4;
   endfunction

   // One-cycle memory that captures the address on an enabled edge
   always @(posedge clk)
   begin
      if (imem_en_o)
         mem_addr_q <= imem_addr_o;
   end

   // Read data settles mid-cycle
   always @(negedge clk)
   begin
      imem_rdata_i <= {mem_word(mem_addr_q + 32'd4), mem_word(mem_addr_q)};
   end

   // Every accepted pop is compared against the reference stream
   always @(posedge clk)
   begin
      if (rst_n_i && id_pop_i && id_valid_o)
      begin
         checks = checks + 1;
         assert (id_pc_o == exp_pc)
         else
         begin
            errors = errors + 1;
            $display("FAIL %0t: pc %h, expected %h", $time, id_pc_o, exp_pc);
         end
         assert (id_ins_o == mem_word(exp_pc))
         else
         begin
            errors = errors + 1;
            $display("FAIL %0t: word %h at pc %h, expected %h", $time, id_ins_o, exp_pc,
                     mem_word(exp_pc));
         end
         assert (id_pred_taken_o == predict_taken(exp_pc))
         else
         begin
            errors = errors + 1;
            $display("FAIL %0t: prediction flag %b at pc %h", $time, id_pred_taken_o, exp_pc);
         end
         if (id_pred_taken_o)
            pred_seen = pred_seen + 1;
         exp_pc    = next_expected_pc(exp_pc);
         pop_count = pop_count + 1;
      end
   end

   // Pop n entries, optionally with random gaps and long stalls
   task automatic pop_entries(input int n, input bit rand_mode);
      int          start;
      int          guard;
      int          stall_left;
      logic [31:0] r;
      start      = pop_count;
      guard      = 0;
      stall_left = 0;
      while (pop_count - start < n)
      begin
         @(negedge clk);
         if (guard > 40 * n + 200)
         begin
            $display("Timeout: only %0d of %0d instructions delivered", pop_count - start, n);
            $display("Result: FAILED");
            $finish;
         end
         guard = guard + 1;
         r     = $random(seed);
         if (stall_left > 0)
         begin
            id_pop_i   = 1'b0;
            stall_left = stall_left - 1;
         end
         else
         begin
            id_pop_i = id_valid_o && (pop_count - start < n) &&
                       (!rand_mode || r[1:0] != 2'd0);
            if (rand_mode && r[6:3] == 4'd0)
               stall_left = 12 + int'(r[11:8]);
         end
      end
   endtask

   // Redirect and check the fixed two-cycle latency
   task automatic flush_to(input fetch_pkg::addr_t tgt);
      @(negedge clk);
      id_pop_i    = 1'b0;
      flush_i     = 1'b1;
      flush_tgt_i = tgt;
      exp_pc      = tgt;
      @(negedge clk);
      flush_i = 1'b0;
      assert (!id_valid_o)
      else
      begin
         errors = errors + 1;
         $display("FAIL %0t: output valid one cycle after flush", $time);
      end
      @(negedge clk);
      assert (id_valid_o && id_pc_o == tgt)
      else
      begin
         errors = errors + 1;
         $display("FAIL %0t: valid %b pc %h two cycles after flush to %h", $time,
                  id_valid_o, id_pc_o, tgt);
      end
   endtask

   task automatic btb_update(input fetch_pkg::addr_t pc, input logic taken,
                             input fetch_pkg::addr_t tgt);
      logic hit;
      hit = mdl_vld[pc[5:2]] && (mdl_pc[pc[5:2]][31:2] == pc[31:2]);
      if (taken)
      begin
         if (!hit)
            mdl_cnt[pc[5:2]] = 2'd2;
         else if (mdl_cnt[pc[5:2]] != 2'd3)
            mdl_cnt[pc[5:2]] = mdl_cnt[pc[5:2]] + 2'd1;
         mdl_vld[pc[5:2]] = 1'b1;
         mdl_pc[pc[5:2]]  = pc;
         mdl_tgt[pc[5:2]] = tgt;
      end
      else if (hit && mdl_cnt[pc[5:2]] != 2'd0)
         mdl_cnt[pc[5:2]] = mdl_cnt[pc[5:2]] - 2'd1;
      @(negedge clk);
      bpu_wb_i       = 1'b1;
      bpu_wb_pc_i    = pc;
      bpu_wb_taken_i = taken;
      bpu_wb_tgt_i   = tgt;
      @(negedge clk);
      bpu_wb_i = 1'b0;
   endtask

   task automatic end_test(input string name);
      tests = tests + 1;
      if (errors == test_start)
         $display("test %0d %s: ok", tests, name);
      else
         $display("test %0d %s: %0d errors", tests, name, errors - test_start);
      test_start = errors;
   endtask

   initial
   begin
      clk            = 1'b0;
      rst_n_i        = 1'b0;
      flush_i        = 1'b0;
      flush_tgt_i    = '0;
      imem_rdata_i   = '0;
      bpu_wb_i       = 1'b0;
      bpu_wb_pc_i    = '0;
      bpu_wb_taken_i = 1'b0;
      bpu_wb_tgt_i   = '0;
      id_pop_i       = 1'b0;
      mem_addr_q     = '0;
      seed           = 13;
      errors         = 0;
      checks         = 0;
      pop_count      = 0;
      pred_seen      = 0;
      tests          = 0;
      test_start     = 0;
      for (int i = 0; i < `FETCH_BTB_ENTRIES; i++)
      begin
         mdl_vld[i] = 1'b0;
         mdl_pc[i]  = '0;
         mdl_tgt[i] = '0;
         mdl_cnt[i] = '0;
      end
      exp_pc = `FETCH_RESET_PC;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n_i = 1'b1;

      // Reset vector is fetched in the first cycle after release
      assert (imem_en_o && imem_addr_o == `FETCH_RESET_PC)
      else
      begin
         errors = errors + 1;
         $display("FAIL %0t: first fetch en %b addr %h, expected %h", $time,
                  imem_en_o, imem_addr_o, `FETCH_RESET_PC);
      end

      pop_entries(24, 1'b0);
      end_test("reset stream");

      flush_to(32'h0000_4000);
      pop_entries(16, 1'b0);
      end_test("aligned flush");

      flush_to(32'h0000_5004);
      pop_entries(10, 1'b0);
      end_test("flush to slot 1");

      flush_to(32'h0000_6000);
      pop_entries(80, 1'b1);
      end_test("random pops with stalls");

      // Taken branch at 0x2000 to 0x3004, then trained back to not taken
      btb_update(32'h0000_2000, 1'b1, 32'h0000_3004);
      flush_to(32'h0000_1ff8);
      mark = pred_seen;
      pop_entries(10, 1'b0);
      assert (pred_seen == mark + 1)
      else
      begin
         errors = errors + 1;
         $display("FAIL %0t: %0d predicted entries, expected 1", $time, pred_seen - mark);
      end
      btb_update(32'h0000_2000, 1'b0, '0);
      btb_update(32'h0000_2000, 1'b0, '0);
      flush_to(32'h0000_1ff8);
      mark = pred_seen;
      pop_entries(10, 1'b0);
      assert (pred_seen == mark)
      else
      begin
         errors = errors + 1;
         $display("FAIL %0t: prediction still active after two not-taken updates", $time);
      end
      end_test("branch prediction");

      errors = errors + u_fetch_top.u_asserts.fail_cnt;
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/fetch_bpu.sv ====
// Direct-mapped branch target buffer with 2-bit counters and registered lookup
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_bpu (
   input  wire                     clk,
   input  wire                     rst_n_i,
   input  wire                     lookup_en_i,
   input  wire fetch_pkg::addr_t   lookup_pc_i,
   input  wire                     wb_i,
   input  wire fetch_pkg::addr_t   wb_pc_i,
   input  wire                     wb_taken_i,
   input  wire fetch_pkg::addr_t   wb_tgt_i,
   output logic [`FETCH_WIDTH-1:0] taken_o,
   output fetch_pkg::addr_t        tgt_o [`FETCH_WIDTH]
);
   localparam int IDXW = $clog2(`FETCH_BTB_ENTRIES);
   localparam int TAGW = `FETCH_AW - IDXW - 2;
   localparam int OFFW = $clog2(`FETCH_WIDTH);
   localparam int WB   = OFFW + 2;

   // Entry storage
   logic [TAGW-1:0]               btb_tag [`FETCH_BTB_ENTRIES];
   fetch_pkg::addr_t              btb_tgt [`FETCH_BTB_ENTRIES];
   fetch_pkg::cnt2_t              btb_cnt [`FETCH_BTB_ENTRIES];
   logic [`FETCH_BTB_ENTRIES-1:0] btb_vld;

   // One read port per slot
   logic [IDXW-1:0]         slot_idx [`FETCH_WIDTH];
   logic [TAGW-1:0]         rd_tag   [`FETCH_WIDTH];
   fetch_pkg::cnt2_t        rd_cnt   [`FETCH_WIDTH];
   logic [`FETCH_WIDTH-1:0] rd_vld;
   logic [TAGW-1:0]         lk_tag;

   logic [IDXW-1:0] wb_idx;
   logic [TAGW-1:0] wb_tag;
   logic            wb_hit;

   // Slots of one window share the tag and differ in the low index bits
   always_comb
   begin
      for (int i = 0; i < `FETCH_WIDTH; i++)
         slot_idx[i] = {lookup_pc_i[WB +: IDXW-OFFW], OFFW'(i)};
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
         rd_vld <= '0;
      else if (lookup_en_i)
      begin
         for (int i = 0; i < `FETCH_WIDTH; i++)
            rd_vld[i] <= btb_vld[slot_idx[i]];
      end
   end

   always_ff @(posedge clk)
   begin
      if (lookup_en_i)
      begin
         lk_tag <= lookup_pc_i[`FETCH_AW-1 -: TAGW];
         for (int i = 0; i < `FETCH_WIDTH; i++)
         begin
            rd_tag[i] <= btb_tag[slot_idx[i]];
            rd_cnt[i] <= btb_cnt[slot_idx[i]];
            tgt_o[i]  <= btb_tgt[slot_idx[i]];
         end
      end
   end

   always_comb
   begin
      for (int i = 0; i < `FETCH_WIDTH; i++)
         taken_o[i] = rd_vld[i] && (rd_tag[i] == lk_tag) && rd_cnt[i][1];
   end

   // Writeback side
   assign wb_idx = wb_pc_i[2 +: IDXW];
   assign wb_tag = wb_pc_i[`FETCH_AW-1 -: TAGW];
   assign wb_hit = btb_vld[wb_idx] && (btb_tag[wb_idx] == wb_tag);

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
         btb_vld <= '0;
      else if (wb_i && wb_taken_i)
         btb_vld[wb_idx] <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (wb_i && wb_taken_i)
      begin
         btb_tag[wb_idx] <= wb_tag;
         btb_tgt[wb_idx] <= wb_tgt_i;
         // New entries start weakly taken
         if (!wb_hit)
            btb_cnt[wb_idx] <= 2'd2;
         else if (btb_cnt[wb_idx] != 2'd3)
            btb_cnt[wb_idx] <= btb_cnt[wb_idx] + 2'd1;
      end
      else if (wb_i && wb_hit && btb_cnt[wb_idx] != 2'd0)
         btb_cnt[wb_idx] <= btb_cnt[wb_idx] - 2'd1;
   end

endmodule

`default_nettype wire

// ==== verilog/fetch_defines.svh ====
// Fetch unit configuration macros for widths, sizes and the reset vector
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Address and instruction widths
`define FETCH_AW           32
`define FETCH_INSN_DW      32

// Instructions per fetch window, two words make an 8-byte window
`define FETCH_WIDTH        2

// Fetch queue entries, must be a power of two
`define FETCH_QUEUE_DEPTH  8

// Direct-mapped BTB indexed by PC[5:2]
`define FETCH_BTB_ENTRIES  16

// First fetch address after reset
`define FETCH_RESET_PC     32'h0000_1000

`endif

// ==== verilog/fetch_pc_gen.sv ====
// Fetch PC register, next-PC selection, slot valid mask and window realignment
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_pc_gen (
   input  wire                                    clk,
   input  wire                                    rst_n_i,
   input  wire                                    flush_i,
   input  wire fetch_pkg::addr_t                  flush_tgt_i,
   input  wire                                    queue_ready_i,
   input  wire [`FETCH_WIDTH-1:0]                 pred_taken_i,
   input  wire fetch_pkg::addr_t                  pred_tgt_i [`FETCH_WIDTH],
   input  wire [`FETCH_WIDTH*`FETCH_INSN_DW-1:0]  s1_rdata_i,
   output fetch_pkg::addr_t                       pc_nxt_o,
   output fetch_pkg::addr_t                       s1_pc_o,
   output fetch_pkg::push_cnt_t                   push_cnt_o,
   output logic [`FETCH_WIDTH-1:0]                s1_pred_taken_o,
   output fetch_pkg::insn_t                       push_ins_o [`FETCH_WIDTH],
   output logic                                   imem_en_o
);
   localparam int OFFW = $clog2(`FETCH_WIDTH);
   localparam int WB   = OFFW + 2;

   fetch_pkg::addr_t        s1_pc;
   logic                    s1_valid;
   logic [OFFW-1:0]         s1_off;
   logic [`FETCH_WIDTH-1:0] slot_vld;
   logic [`FETCH_WIDTH-1:0] slot_tkn;
   fetch_pkg::push_cnt_t    n_vld;
   fetch_pkg::addr_t        pred_pc;
   fetch_pkg::addr_t        seq_pc;

   // Slot of the first instruction inside the window
   assign s1_off = s1_pc[2 +: OFFW];
   assign seq_pc = {s1_pc[`FETCH_AW-1:WB], {WB{1'b0}}} + fetch_pkg::addr_t'(`FETCH_WIDTH * 4);

   // Valid from the entry slot up to the first predicted-taken slot
   always_comb
   begin
      logic blocked;
      blocked = 1'b0;
      n_vld   = '0;
      for (int i = 0; i < `FETCH_WIDTH; i++)
      begin
         slot_vld[i] = (s1_off <= i) && !blocked;
         slot_tkn[i] = slot_vld[i] & pred_taken_i[i];
         blocked     = blocked | slot_tkn[i];
         n_vld       = n_vld + fetch_pkg::push_cnt_t'(slot_vld[i]);
      end
   end

   // Lowest taken slot wins
   always_comb
   begin
      pred_pc = seq_pc;
      for (int i = `FETCH_WIDTH - 1; i >= 0; i--)
      begin
         if (slot_tkn[i])
            pred_pc = pred_tgt_i[i];
      end
   end

   always_comb
   begin
      if (flush_i)
         pc_nxt_o = flush_tgt_i;
      else if (!queue_ready_i || !s1_valid)
         pc_nxt_o = s1_pc;
      else if (|slot_tkn)
         pc_nxt_o = pred_pc;
      else
         pc_nxt_o = seq_pc;
   end

   // A flush always fetches since the queue empties on the same edge
   assign imem_en_o  = flush_i | queue_ready_i;
   assign push_cnt_o = (flush_i || !s1_valid || !queue_ready_i) ? '0 : n_vld;
   assign s1_pc_o    = s1_pc;

   // Shift the window so the entry slot lands in lane 0
   always_comb
   begin
      logic [OFFW-1:0] src;
      for (int k = 0; k < `FETCH_WIDTH; k++)
      begin
         src                = OFFW'(k + s1_off);
         push_ins_o[k]      = s1_rdata_i[src*`FETCH_INSN_DW +: `FETCH_INSN_DW];
         s1_pred_taken_o[k] = slot_tkn[src];
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         s1_pc    <= `FETCH_RESET_PC;
         s1_valid <= 1'b0;
      end
      else if (imem_en_o)
      begin
         s1_pc    <= pc_nxt_o;
         s1_valid <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/fetch_pkg.sv ====
// Shared vector types of the fetch unit
`default_nettype none

`include "fetch_defines.svh"

package fetch_pkg;

   // Byte address
   typedef logic [`FETCH_AW-1:0] addr_t;

   // One instruction word
   typedef logic [`FETCH_INSN_DW-1:0] insn_t;

   // Saturating branch counter, taken when 2 or 3
   typedef logic [1:0] cnt2_t;

   // Instructions pushed in one cycle, 0 up to FETCH_WIDTH
   typedef logic [$clog2(`FETCH_WIDTH+1)-1:0] push_cnt_t;

   // Queue pointer with an extra wrap bit
   typedef logic [$clog2(`FETCH_QUEUE_DEPTH):0] qptr_t;

endpackage

`default_nettype wire

// ==== verilog/fetch_queue.sv ====
// Fetch queue, circular buffer with two-wide push and single pop
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_queue (
   input  wire                       clk,
   input  wire                       rst_n_i,
   input  wire                       flush_i,
   input  wire fetch_pkg::push_cnt_t push_cnt_i,
   input  wire fetch_pkg::insn_t     push_ins_i [`FETCH_WIDTH],
   input  wire fetch_pkg::addr_t     push_pc_i,
   input  wire [`FETCH_WIDTH-1:0]    push_pred_i,
   output logic                      queue_ready_o,
   output logic                      id_valid_o,
   output fetch_pkg::insn_t          id_ins_o,
   output fetch_pkg::addr_t          id_pc_o,
   output logic                      id_pred_taken_o,
   input  wire                       id_pop_i
);
   localparam int PW = $clog2(`FETCH_QUEUE_DEPTH);

   // Entry storage
   fetch_pkg::insn_t              q_ins [`FETCH_QUEUE_DEPTH];
   fetch_pkg::addr_t              q_pc  [`FETCH_QUEUE_DEPTH];
   logic [`FETCH_QUEUE_DEPTH-1:0] q_pred;

   fetch_pkg::qptr_t head;
   fetch_pkg::qptr_t tail;
   fetch_pkg::qptr_t used;
   logic             pop;

   logic [PW-1:0]    wr_idx [`FETCH_WIDTH];
   fetch_pkg::addr_t wr_pc  [`FETCH_WIDTH];

   assign used = tail - head;

   // Room for a whole window
   assign queue_ready_o = (used <= fetch_pkg::qptr_t'(`FETCH_QUEUE_DEPTH - `FETCH_WIDTH));

   assign id_valid_o      = (head != tail);
   assign pop             = id_pop_i & id_valid_o;
   assign id_ins_o        = q_ins[head[PW-1:0]];
   assign id_pc_o         = q_pc[head[PW-1:0]];
   assign id_pred_taken_o = q_pred[head[PW-1:0]];

   // Lane k goes to tail+k with PC base+4k
   always_comb
   begin
      for (int k = 0; k < `FETCH_WIDTH; k++)
      begin
         wr_idx[k] = tail[PW-1:0] + PW'(k);
         wr_pc[k]  = push_pc_i + fetch_pkg::addr_t'(4 * k);
      end
   end

   always_ff @(posedge clk)
   begin
      for (int k = 0; k < `FETCH_WIDTH; k++)
      begin
         if (k < push_cnt_i)
         begin
            q_ins[wr_idx[k]]  <= push_ins_i[k];
            q_pc[wr_idx[k]]   <= wr_pc[k];
            q_pred[wr_idx[k]] <= push_pred_i[k];
         end
      end
   end

   // Flush drops every entry, pending pops included
   always_ff @(posedge clk)
   begin
      if (!rst_n_i || flush_i)
      begin
         head <= '0;
         tail <= '0;
      end
      else
      begin
         if (pop)
            head <= head + 1'b1;
         tail <= tail + fetch_pkg::qptr_t'(push_cnt_i);
      end
   end

endmodule

`default_nettype wire

// ==== verilog/fetch_top.sv ====
// Instruction fetch unit top level with PC generator, BTB and fetch queue
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_top (
   input  wire                                    clk,
   input  wire                                    rst_n_i,
   // Redirect
   input  wire                                    flush_i,
   input  wire fetch_pkg::addr_t                  flush_tgt_i,
   // Instruction memory
   output logic                                   imem_en_o,
   output fetch_pkg::addr_t                       imem_addr_o,
   input  wire [`FETCH_WIDTH*`FETCH_INSN_DW-1:0]  imem_rdata_i,
   // Branch update from execute
   input  wire                                    bpu_wb_i,
   input  wire fetch_pkg::addr_t                  bpu_wb_pc_i,
   input  wire                                    bpu_wb_taken_i,
   input  wire fetch_pkg::addr_t                  bpu_wb_tgt_i,
   // Decode
   output logic                                   id_valid_o,
   output fetch_pkg::insn_t                       id_ins_o,
   output fetch_pkg::addr_t                       id_pc_o,
   output logic                                   id_pred_taken_o,
   input  wire                                    id_pop_i
);
   localparam int WB = $clog2(`FETCH_WIDTH) + 2;

   fetch_pkg::addr_t        pc_nxt;
   fetch_pkg::addr_t        s1_pc;
   fetch_pkg::push_cnt_t    push_cnt;
   logic [`FETCH_WIDTH-1:0] s1_pred_taken;
   fetch_pkg::insn_t        push_ins [`FETCH_WIDTH];
   logic [`FETCH_WIDTH-1:0] pred_taken;
   fetch_pkg::addr_t        pred_tgt [`FETCH_WIDTH];
   logic                    queue_ready;

   // Memory sees the window base only
   assign imem_addr_o = {pc_nxt[`FETCH_AW-1:WB], {WB{1'b0}}};

   fetch_pc_gen u_pc_gen (
      .clk             (clk),
      .rst_n_i         (rst_n_i),
      .flush_i         (flush_i),
      .flush_tgt_i     (flush_tgt_i),
      .queue_ready_i   (queue_ready),
      .pred_taken_i    (pred_taken),
      .pred_tgt_i      (pred_tgt),
      .s1_rdata_i      (imem_rdata_i),
      .pc_nxt_o        (pc_nxt),
      .s1_pc_o         (s1_pc),
      .push_cnt_o      (push_cnt),
      .s1_pred_taken_o (s1_pred_taken),
      .push_ins_o      (push_ins),
      .imem_en_o       (imem_en_o)
   );

   // Lookup advances together with the memory read
   fetch_bpu u_bpu (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .lookup_en_i (imem_en_o),
      .lookup_pc_i (pc_nxt),
      .wb_i        (bpu_wb_i),
      .wb_pc_i     (bpu_wb_pc_i),
      .wb_taken_i  (bpu_wb_taken_i),
      .wb_tgt_i    (bpu_wb_tgt_i),
      .taken_o     (pred_taken),
      .tgt_o       (pred_tgt)
   );

   fetch_queue u_queue (
      .clk             (clk),
      .rst_n_i         (rst_n_i),
      .flush_i         (flush_i),
      .push_cnt_i      (push_cnt),
      .push_ins_i      (push_ins),
      .push_pc_i       (s1_pc),
      .push_pred_i     (s1_pred_taken),
      .queue_ready_o   (queue_ready),
      .id_valid_o      (id_valid_o),
      .id_ins_o        (id_ins_o),
      .id_pc_o         (id_pc_o),
      .id_pred_taken_o (id_pred_taken_o),
      .id_pop_i        (id_pop_i)
   );

endmodule

`default_nettype wire
